// ==== design/line_memory.sv ====
`default_nettype none

module line_memory
    import segre_pkg::*;
#(
    parameter int MEM_BYTES   = 65536,
    parameter int MEM_LATENCY = 10
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    mem_line_if.mem port
);

    localparam int AW    = $clog2(MEM_BYTES);
    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int CNT_W = $clog2(MEM_LATENCY);

    logic [7:0]          mem [MEM_BYTES];
    logic [AW-OFF_W-1:0] line_idx;      // Line number inside the array
    line_t               line_q;        // Line captured at issue
    line_t               rdata_q;
    logic                busy_q;
    logic                data_rdy_q;
    logic [CNT_W-1:0]    cnt_q;         // Cycles left until data_rdy

    assign line_idx = port.addr[AW-1:OFF_W];

    // Zero everything, then the alternating data pattern
    initial begin
        logic [31:0] word;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        for (int w = 0; w < DATA_PATTERN_WORDS; w++) begin
            word = ((w / 5) % 2 == 0) ? PATTERN_A : PATTERN_B;  // Blocks of five words
            for (int b = 0; b < 4; b++) begin
                mem[AW'(DATA_BASE + 4 * w + b)] = word[8*b +: 8];  // Little-endian
            end
        end
    end

    // Whole line written in one cycle
    always @(posedge clk_i) begin
        if (port.wr) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                mem[{line_idx, OFF_W'(b)}] <= port.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (port.rd) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                line_q[8*b +: 8] <= mem[{line_idx, OFF_W'(b)}];  // Byte 0 in low bits
            end
        end
    end

    // Read latency counter
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            data_rdy_q <= 1'b0;
            cnt_q      <= '0;
            rdata_q    <= '0;
        end else begin
            data_rdy_q <= 1'b0;
            if (port.rd) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(MEM_LATENCY - 1);
            end else if (busy_q && cnt_q == '0) begin
                busy_q     <= 1'b0;      // Drops with the data_rdy pulse
                data_rdy_q <= 1'b1;
                rdata_q    <= line_q;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign port.busy     = busy_q;
    assign port.data_rdy = data_rdy_q;
    assign port.rdata    = rdata_q;

    a_addr_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (port.rd || port.wr) |-> (port.addr[OFF_W-1:0] == '0)
    );

    a_addr_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (port.rd || port.wr) |-> (port.addr < MEM_BYTES)
    );

    // Issue to response is fixed
    a_read_latency: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        port.rd |-> ##(MEM_LATENCY + 1) port.data_rdy
    );

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter
    import segre_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    mem_line_if.mem    ic_port,
    mem_line_if.mem    dc_port,
    mem_line_if.client mem_port
);

    localparam logic IC = 1'b0;
    localparam logic DC = 1'b1;

    // Peer signals gathered by index, 0 is IC and 1 is DC
    logic [1:0] cl_rd;
    logic [1:0] cl_wr;
    addr_t      cl_addr [2];
    line_t      cl_wdata [2];
    logic [1:0] cl_busy;

    logic [1:0] pend_q;                 // Request waiting or in service
    logic [1:0] pend_wr_q;
    addr_t      pend_addr_q [2];
    line_t      pend_wdata_q [2];

    logic       issued_q;               // Something issued last cycle
    logic       issued_wr_q;
    logic       rd_inflight_q;
    logic       owner_q;                // Peer of the read in flight
    logic       last_q;                 // Peer served last

    logic       can_issue;
    logic       issue;
    logic       sel;
    logic [1:0] rd_done;
    logic [1:0] wr_done;

    assign cl_rd[IC]    = ic_port.rd;
    assign cl_wr[IC]    = ic_port.wr;
    assign cl_addr[IC]  = ic_port.addr;
    assign cl_wdata[IC] = ic_port.wdata;
    assign cl_rd[DC]    = dc_port.rd;
    assign cl_wr[DC]    = dc_port.wr;
    assign cl_addr[DC]  = dc_port.addr;
    assign cl_wdata[DC] = dc_port.wdata;

    // Round robin only matters on a tie
    assign can_issue = !mem_port.busy && !issued_q && !rd_inflight_q;
    assign sel       = (&pend_q) ? ~last_q : pend_q[DC];
    assign issue     = can_issue && (|pend_q);

    assign mem_port.rd    = issue && !pend_wr_q[sel];
    assign mem_port.wr    = issue && pend_wr_q[sel];
    assign mem_port.addr  = pend_addr_q[sel];
    assign mem_port.wdata = pend_wdata_q[sel];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_done[i] = mem_port.data_rdy && rd_inflight_q && (owner_q == 1'(i));
            wr_done[i] = issued_q && issued_wr_q && (last_q == 1'(i));
        end
    end

    assign cl_busy = pend_q & ~rd_done;  // Falls together with data_rdy

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q    <= '0;
            pend_wr_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cl_rd[i] || cl_wr[i]) begin
                    pend_q[i]    <= 1'b1;
                    pend_wr_q[i] <= cl_wr[i];
                end else if (rd_done[i] || wr_done[i]) begin
                    pend_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 2; i++) begin
            if (cl_rd[i] || cl_wr[i]) begin
                pend_addr_q[i]  <= cl_addr[i];
                pend_wdata_q[i] <= cl_wdata[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issued_q      <= 1'b0;
            issued_wr_q   <= 1'b0;
            rd_inflight_q <= 1'b0;
            owner_q       <= IC;
            last_q        <= IC;        // DC wins the first tie
        end else begin
            issued_q    <= issue;
            issued_wr_q <= mem_port.wr;
            if (issue) begin
                last_q <= sel;
            end
            if (mem_port.rd) begin
                rd_inflight_q <= 1'b1;
                owner_q       <= sel;
            end else if (mem_port.data_rdy) begin
                rd_inflight_q <= 1'b0;
            end
        end
    end

    assign ic_port.busy     = cl_busy[IC];
    assign ic_port.data_rdy = rd_done[IC];
    assign ic_port.rdata    = (owner_q == IC) ? mem_port.rdata : '0;
    assign dc_port.busy     = cl_busy[DC];
    assign dc_port.data_rdy = rd_done[DC];
    assign dc_port.rdata    = (owner_q == DC) ? mem_port.rdata : '0;

    for (genvar g = 0; g < 2; g++) begin : g_proto
        a_no_strobe_busy: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (cl_rd[g] || cl_wr[g]) |-> !cl_busy[g]
        );
        a_single_pulse: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            (cl_rd[g] || cl_wr[g]) |=> !(cl_rd[g] || cl_wr[g])
        );
        a_rd_wr_excl: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            !(cl_rd[g] && cl_wr[g])
        );
    end

endmodule

`default_nettype wire

// ==== design/mem_line_if.sv ====
`default_nettype none

interface mem_line_if
    import segre_pkg::*;
();

    logic  rd;        // Read strobe, one cycle
    logic  wr;        // Write strobe, one cycle
    addr_t addr;      // Line-aligned byte address
    line_t wdata;
    logic  busy;      // Level, no strobe allowed while high
    logic  data_rdy;  // One-cycle pulse, rdata valid
    line_t rdata;

    // Requesting side
    modport client (
        output rd, wr, addr, wdata,
        input  busy, data_rdy, rdata
    );

    // Serving side
    modport mem (
        input  rd, wr, addr, wdata,
        output busy, data_rdy, rdata
    );

endinterface

`default_nettype wire

// ==== design/segre_mem_subsys.sv ====
`default_nettype none

module segre_mem_subsys
    import segre_pkg::*;
#(
    parameter int MEM_BYTES   = 65536,
    parameter int MEM_LATENCY = 10
) (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Instruction refill port, read only
    input  logic  ic_rd_i,
    input  addr_t ic_addr_i,
    output logic  ic_busy_o,
    output logic  ic_data_rdy_o,
    output line_t ic_rdata_o,

    // Data refill and writeback port
    input  logic  dc_rd_i,
    input  logic  dc_wr_i,
    input  addr_t dc_addr_i,
    input  line_t dc_wdata_i,
    output logic  dc_busy_o,
    output logic  dc_data_rdy_o,
    output line_t dc_rdata_o
);

    mem_line_if ic_ch ();
    mem_line_if dc_ch ();
    mem_line_if mem_ch ();

    assign ic_ch.rd      = ic_rd_i;
    assign ic_ch.wr      = 1'b0;     // No writes from the instruction side
    assign ic_ch.addr    = ic_addr_i;
    assign ic_ch.wdata   = '0;
    assign ic_busy_o     = ic_ch.busy;
    assign ic_data_rdy_o = ic_ch.data_rdy;
    assign ic_rdata_o    = ic_ch.rdata;

    assign dc_ch.rd      = dc_rd_i;
    assign dc_ch.wr      = dc_wr_i;
    assign dc_ch.addr    = dc_addr_i;
    assign dc_ch.wdata   = dc_wdata_i;
    assign dc_busy_o     = dc_ch.busy;
    assign dc_data_rdy_o = dc_ch.data_rdy;
    assign dc_rdata_o    = dc_ch.rdata;

    mem_arbiter i_mem_arbiter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ic_port  (ic_ch),
        .dc_port  (dc_ch),
        .mem_port (mem_ch)
    );

    line_memory #(
        .MEM_BYTES   (MEM_BYTES),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_line_memory (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port    (mem_ch)
    );

endmodule

`default_nettype wire

// ==== design/segre_pkg.sv ====
`default_nettype none

package segre_pkg;

    localparam int WORD_SIZE        = 32;      // Address width
    localparam int DCACHE_LANE_SIZE = 128;     // Cache line width
    localparam int LINE_BYTES       = DCACHE_LANE_SIZE / 8;

    typedef logic [DCACHE_LANE_SIZE-1:0] line_t;
    typedef logic [WORD_SIZE-1:0]        addr_t;

    // Data region preload
    localparam addr_t       DATA_BASE          = 32'h0001_2000;
    localparam int          DATA_PATTERN_WORDS = 20;
    localparam logic [31:0] PATTERN_A          = 32'hfafa_fafa;  // Words 0-4 and 10-14
    localparam logic [31:0] PATTERN_B          = 32'h5a5a_5a5a;  // Words 5-9 and 15-19

endpackage

`default_nettype wire

// ==== testbench/tb_segre_mem_subsys.sv ====
`default_nettype none

module tb_segre_mem_subsys
    import segre_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_BYTES   = 131072;  // Power of two above DATA_BASE plus the pattern
    localparam int MEM_LATENCY = 10;
    localparam int TIMEOUT     = 200;     // Cycles allowed per wait
    localparam bit IC          = 1'b0;
    localparam bit DC          = 1'b1;

    logic  clk_i;
    logic  rst_n_i;
    logic  ic_rd_i;
    addr_t ic_addr_i;
    logic  ic_busy_o;
    logic  ic_data_rdy_o;
    line_t ic_rdata_o;
    logic  dc_rd_i;
    logic  dc_wr_i;
    addr_t dc_addr_i;
    line_t dc_wdata_i;
    logic  dc_busy_o;
    logic  dc_data_rdy_o;
    line_t dc_rdata_o;

    logic [7:0]  ref_mem [MEM_BYTES];  // Reference memory, byte per entry
    logic [31:0] rng_state;
    int          num_errors;
    int          num_checks;
    bit          last_served;           // Port that the arbiter served last

    segre_mem_subsys #(
        .MEM_BYTES   (MEM_BYTES),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_segre_mem_subsys (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ic_rd_i       (ic_rd_i),
        .ic_addr_i     (ic_addr_i),
        .ic_busy_o     (ic_busy_o),
        .ic_data_rdy_o (ic_data_rdy_o),
        .ic_rdata_o    (ic_rdata_o),
        .dc_rd_i       (dc_rd_i),
        .dc_wr_i       (dc_wr_i),
        .dc_addr_i     (dc_addr_i),
        .dc_wdata_i    (dc_wdata_i),
        .dc_busy_o     (dc_busy_o),
        .dc_data_rdy_o (dc_data_rdy_o),
        .dc_rdata_o    (dc_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic line_t rand_line();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] == 2'b00) begin
            return DATA_BASE + 16 * (r[7:0] % 5);  // Hit the pattern lines now and then
        end
        return {15'h0, r[16:4], 4'h0};
    endfunction

    // Words 0-4 and 10-14 get pattern A, the rest of the twenty get B
    task automatic ref_init();
        logic [31:0] word;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        for (int w = 0; w < DATA_PATTERN_WORDS; w++) begin
            word = (w < 5 || (w >= 10 && w < 15)) ? PATTERN_A : PATTERN_B;
            for (int b = 0; b < 4; b++) begin
                ref_mem[DATA_BASE + 4 * w + b] = word[8*b +: 8];
            end
        end
    endtask

    function automatic line_t ref_line(input addr_t addr);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[8*b +: 8] = ref_mem[addr + b];  // Little-endian
        end
        return l;
    endfunction

    task automatic check(input string name, input line_t got, input line_t exp);
        num_checks++;
        if (got !== exp) begin
            num_errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic line_read(input bit use_dc, input addr_t addr, output line_t data,
                             output int lat);
        string bname;
        bit    done;
        bname = use_dc ? "dc_busy_o" : "ic_busy_o";
        @(negedge clk_i);
        dc_rd_i   = use_dc;
        ic_rd_i   = !use_dc;
        dc_addr_i = addr;
        ic_addr_i = addr;
        @(negedge clk_i);
        dc_rd_i = 1'b0;
        ic_rd_i = 1'b0;
        lat     = 0;
        done    = 1'b0;
        data    = '0;
        while (!done && lat < TIMEOUT) begin
            check(bname, use_dc ? dc_busy_o : ic_busy_o, 1'b1);  // High until data_rdy
            @(negedge clk_i);
            lat++;
            if (use_dc ? dc_data_rdy_o : ic_data_rdy_o) begin
                done = 1'b1;
                data = use_dc ? dc_rdata_o : ic_rdata_o;
                check(bname, use_dc ? dc_busy_o : ic_busy_o, 1'b0);
            end
        end
        if (!done) begin
            num_errors++;
            $display("Read of address %h timed out waiting for data_rdy", addr);
        end
        last_served = use_dc;
    endtask

    task automatic line_write(input addr_t addr, input line_t data, output int lat);
        bit done;
        @(negedge clk_i);
        dc_wr_i    = 1'b1;
        dc_addr_i  = addr;
        dc_wdata_i = data;
        @(negedge clk_i);
        dc_wr_i = 1'b0;
        lat     = 0;
        done    = 1'b0;
        while (!done && lat < TIMEOUT) begin
            @(negedge clk_i);
            lat++;
            done = !dc_busy_o;
        end
        if (!done) begin
            num_errors++;
            $display("Write to address %h timed out waiting for busy to fall", addr);
        end
        for (int b = 0; b < LINE_BYTES; b++) begin
            ref_mem[addr + b] = data[8*b +: 8];
        end
        last_served = DC;
    endtask

    task automatic read_and_compare(input bit use_dc, input addr_t addr);
        line_t data;
        int    lat;
        line_read(use_dc, addr, data, lat);
        check(use_dc ? "dc_rdata_o" : "ic_rdata_o", data, ref_line(addr));
    endtask

    // Both ports strobe in one cycle, the port not served last should finish first
    task automatic tie_read(input addr_t ic_addr, input addr_t dc_addr);
        bit    exp_dc_first;
        int    cyc;
        int    ic_cyc;
        int    dc_cyc;
        line_t ic_data;
        line_t dc_data;
        exp_dc_first = (last_served == IC);
        @(negedge clk_i);
        ic_rd_i   = 1'b1;
        ic_addr_i = ic_addr;
        dc_rd_i   = 1'b1;
        dc_addr_i = dc_addr;
        @(negedge clk_i);
        ic_rd_i = 1'b0;
        dc_rd_i = 1'b0;
        cyc     = 0;
        ic_cyc  = 0;
        dc_cyc  = 0;
        ic_data = '0;
        dc_data = '0;
        while ((ic_cyc == 0 || dc_cyc == 0) && cyc < TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
            if (ic_data_rdy_o) begin
                ic_cyc  = cyc;
                ic_data = ic_rdata_o;
            end
            if (dc_data_rdy_o) begin
                dc_cyc  = cyc;
                dc_data = dc_rdata_o;
            end
        end
        if (ic_cyc == 0 || dc_cyc == 0) begin
            num_errors++;
            $display("Simultaneous reads timed out, one port never saw data_rdy");
        end
        check("ic_rdata_o", ic_data, ref_line(ic_addr));
        check("dc_rdata_o", dc_data, ref_line(dc_addr));
        check("dc_data_rdy_o first", dc_cyc < ic_cyc, exp_dc_first);
        last_served = (dc_cyc < ic_cyc) ? IC : DC;  // Later one was served last
    endtask

    task automatic test_reset_state();
        check("ic_busy_o", ic_busy_o, 1'b0);
        check("ic_data_rdy_o", ic_data_rdy_o, 1'b0);
        check("ic_rdata_o", ic_rdata_o, '0);
        check("dc_busy_o", dc_busy_o, 1'b0);
        check("dc_data_rdy_o", dc_data_rdy_o, 1'b0);
        check("dc_rdata_o", dc_rdata_o, '0);
    endtask

    task automatic test_preload();
        addr_t outside [4] = '{32'h0, 32'h1000, DATA_BASE + 32'h50, 32'h1fff0};
        line_t data;
        int    lat;
        for (int k = 0; k < 5; k++) begin
            read_and_compare(DC, DATA_BASE + 16 * k);
        end
        foreach (outside[i]) begin
            line_read(IC, outside[i], data, lat);
            check("ic_rdata_o", data, '0);
        end
    endtask

    task automatic test_latency();
        line_t data;
        int    lat;
        line_read(DC, DATA_BASE, data, lat);
        check("dc read latency", lat, 1 + MEM_LATENCY);
        line_read(IC, DATA_BASE + 16, data, lat);
        check("ic read latency", lat, 1 + MEM_LATENCY);
        check("ic_rdata_o", data, ref_line(DATA_BASE + 16));
        line_write(32'h100, rand_line(), lat);
        check("dc write busy cycles", lat, 2);
    endtask

    task automatic test_write_readback();
        addr_t addr;
        int    lat;
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr();
            line_write(addr, rand_line(), lat);
            read_and_compare(DC, addr);
        end
    endtask

    task automatic test_shared();
        addr_t addr;
        int    lat;
        addr = rand_addr();
        line_write(addr, rand_line(), lat);
        read_and_compare(IC, addr);
    endtask

    task automatic test_contention();
        int lat;
        tie_read(DATA_BASE, DATA_BASE + 32);
        line_write(32'h240, rand_line(), lat);  // Data port becomes the one served last
        tie_read(32'h240, DATA_BASE + 48);
    endtask

    task automatic test_random();
        logic [31:0] r;
        addr_t       addr;
        int          lat;
        for (int i = 0; i < 60; i++) begin
            r    = next_rand();
            addr = rand_addr();
            if (r[0] && r[1]) begin
                line_write(addr, rand_line(), lat);
            end else begin
                read_and_compare(r[0], addr);
            end
        end
    endtask

    initial begin
        rng_state   = 32'h704f_7c53;
        num_errors  = 0;
        num_checks  = 0;
        last_served = IC;                 // Arbiter state after reset
        rst_n_i     = 1'b0;
        ic_rd_i     = 1'b0;
        ic_addr_i   = '0;
        dc_rd_i     = 1'b0;
        dc_wr_i     = 1'b0;
        dc_addr_i   = '0;
        dc_wdata_i  = '0;
        ref_init();
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        test_reset_state();
        test_preload();
        test_latency();
        test_write_readback();
        test_shared();
        test_contention();
        test_random();
        @(negedge clk_i);
        $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/segre_pkg.sv
design/mem_line_if.sv
design/line_memory.sv
design/mem_arbiter.sv
design/segre_mem_subsys.sv
testbench/tb_segre_mem_subsys.sv
